// File: source/mem_pkg.sv
`default_nettype none

// Memory side of the fetch unit
// One request per 64-byte line, responses come back in request order
package mem_pkg;

    localparam int INDEX_W = 19;    // Address bits 21 down to 3
    localparam int LINE_W  = 512;   // 64 bytes per line

    // Line index as seen by memory
    // Bits 2..0 of the index are always zero since lines are 64-byte aligned
    typedef logic [INDEX_W-1:0] line_index_t;

    // Full line payload, word 0 in the low bits
    typedef logic [LINE_W-1:0] line_data_t;

    // Line request
    // Index only moves under valid on a flush
    typedef struct packed {
        logic        valid;
        line_index_t index;
    } mem_req_t;

    // Line response, one per accepted request
    typedef struct packed {
        logic       valid;
        line_data_t data;
    } mem_resp_t;

endpackage

`default_nettype wire

// File: source/fetch_pkg.sv
`default_nettype none

// Core side of the fetch unit
package fetch_pkg;

    localparam int ADDR_W = 48;
    localparam int INST_W = 32;
    localparam int WORD_W = 4;      // 16 words per line

    typedef logic [ADDR_W-1:0] addr_t;  // Byte address
    typedef logic [INST_W-1:0] inst_t;  // Instruction word

    // One instruction handed to decode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_inst_t;

    // Restart event, valid for a single cycle
    typedef struct packed {
        logic  valid;
        addr_t target;
    } flush_t;

    // Buffered line
    // pc is the 64-byte aligned base, start_word skips words before a branch target
    typedef struct packed {
        addr_t               pc;
        logic [WORD_W-1:0]   start_word;
        mem_pkg::line_data_t data;
    } buf_entry_t;

    typedef enum logic [1:0] {IDLE, REQUEST, WAIT_CREDIT} pc_state_e;
    typedef enum logic {EMPTY, SLICING} slice_state_e;

endpackage

`default_nettype wire

// File: source/pc_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

// Program counter and line request issue
// Credits bound the number of lines in flight plus lines held in the buffer
module pc_ctrl #(
    parameter int LINE_DEPTH = 4
) (
    input  wire logic                              clock,
    input  wire logic                              reset_n,
    input  wire fetch_pkg::addr_t                  boot_addr,
    input  wire logic                              interrupt_valid,
    input  wire fetch_pkg::addr_t                  interrupt_addr,
    input  wire logic                              redirect_valid,
    input  wire fetch_pkg::addr_t                  redirect_target,
    input  wire logic [$clog2(LINE_DEPTH+1)-1:0]   credit_return,
    output mem_pkg::mem_req_t                      mem_req,
    input  wire logic                              mem_req_ready,
    output fetch_pkg::buf_entry_t                  issue,
    output logic                                   issue_valid,   // Request accepted this cycle
    output fetch_pkg::flush_t                      flush
);

    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int CNT_W = $clog2(LINE_DEPTH + 1);

    pc_state_e          state;
    pc_state_e          state_nxt;
    addr_t              pc;             // May hold a mid-line target until its line is requested
    addr_t              line_base;      // pc rounded down to the line
    logic [WORD_W-1:0]  start_word;     // First word to use from the requested line
    logic [CNT_W-1:0]   credits;
    logic [CNT_W-1:0]   credits_nxt;
    logic               accepted;
    logic               restart;
    addr_t              restart_pc;
    line_index_t        req_index;
    logic               flush_valid_q;
    addr_t              flush_target_q;

    assign line_base = {pc[ADDR_W-1:6], 6'b0};
    assign req_index = line_base[21:3];

    // Only the REQUEST state raises valid, and it is never entered without a credit
    assign mem_req = '{valid: (state == REQUEST), index: req_index};
    assign accepted = mem_req.valid && mem_req_ready;

    // Restart source priority
    assign restart    = interrupt_valid || redirect_valid;
    assign restart_pc = interrupt_valid ? interrupt_addr : redirect_target; // Interrupt wins

    // Returned credits and the spent one land in the same cycle
    assign credits_nxt = credits + credit_return - CNT_W'(accepted);

    // Metadata for the buffer, data follows with the response
    assign issue       = '{pc: line_base, start_word: start_word, data: '0};
    assign issue_valid = accepted;

    assign flush = '{valid: flush_valid_q, target: flush_target_q};

    always_comb begin
        case (state)
            IDLE: begin
                state_nxt = REQUEST;    // Full credit pool right after reset
            end
            REQUEST, WAIT_CREDIT: begin
                // Stall when the last credit was just spent
                state_nxt = (credits_nxt != '0) ? REQUEST : WAIT_CREDIT;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pc            <= boot_addr;     // Tracks boot_addr for as long as reset is held
            start_word    <= '0;            // Boot stream begins at the line base
            state         <= IDLE;
            credits       <= CNT_W'(LINE_DEPTH);
            flush_valid_q <= 1'b0;
        end else begin
            state         <= state_nxt;
            credits       <= credits_nxt;
            flush_valid_q <= restart;       // One cycle pulse after the restart edge
            if (restart) begin
                // Jump wins over a request accepted in the same cycle
                pc         <= restart_pc;
                start_word <= restart_pc[5:2];
            end else if (accepted) begin
                pc         <= line_base + addr_t'(64);
                start_word <= '0;           // Sequential lines start at word 0
            end
        end
    end

    // Flush target rides along with the pulse
    always_ff @(posedge clock) begin
        if (restart) begin
            flush_target_q <= restart_pc;
        end
    end

endmodule

`default_nettype wire

// File: source/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// Line buffer between memory and the slicer
// A slot is claimed at request time and filled when its response arrives
module line_buffer #(
    parameter int LINE_DEPTH = 4
) (
    input  wire logic                              clock,
    input  wire logic                              reset_n,
    input  wire fetch_pkg::buf_entry_t             issue,
    input  wire logic                              issue_valid,
    input  wire mem_pkg::mem_resp_t                mem_resp,
    input  wire fetch_pkg::flush_t                 flush,
    output fetch_pkg::buf_entry_t                  head,
    output logic                                   head_valid,
    input  wire logic                              pop,
    output logic [$clog2(LINE_DEPTH+1)-1:0]        credit_return
);

    import fetch_pkg::*;

    localparam int PTR_W = $clog2(LINE_DEPTH);
    localparam int CNT_W = $clog2(LINE_DEPTH + 1);

    buf_entry_t         entries [LINE_DEPTH];
    logic [PTR_W-1:0]   rd_ptr;         // Oldest filled line
    logic [PTR_W-1:0]   fill_ptr;       // Oldest slot still waiting for data
    logic [PTR_W-1:0]   wr_ptr;         // Next free slot
    logic [PTR_W-1:0]   wr_slot;
    logic [CNT_W-1:0]   filled_cnt;
    logic [CNT_W-1:0]   pending_cnt;
    logic [CNT_W-1:0]   drop_cnt;       // Responses still owed to a flushed stream
    logic [CNT_W-1:0]   credit_q;
    logic               resp_drop;
    logic               resp_fill;
    logic               pop_ok;

    // Ring step that also works for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(LINE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Responses arrive in order, so the oldest ones belong to the flushed stream
    assign resp_drop = mem_resp.valid && (flush.valid || (drop_cnt != '0));
    assign resp_fill = mem_resp.valid && !resp_drop;
    assign pop_ok    = pop && head_valid;
    assign wr_slot   = flush.valid ? '0 : wr_ptr;    // Ring restarts at slot 0 on flush

    assign head          = entries[rd_ptr];
    assign head_valid    = (filled_cnt != '0);
    assign credit_return = credit_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr      <= '0;
            fill_ptr    <= '0;
            wr_ptr      <= '0;
            filled_cnt  <= '0;
            pending_cnt <= '0;
            drop_cnt    <= '0;
            credit_q    <= '0;
        end else if (flush.valid) begin
            rd_ptr      <= '0;
            fill_ptr    <= '0;
            // The request raised in the flush cycle already belongs to the new stream
            wr_ptr      <= issue_valid ? next_ptr('0) : '0;
            filled_cnt  <= '0;
            pending_cnt <= CNT_W'(issue_valid);
            // Every old request still out must be answered and thrown away
            drop_cnt    <= drop_cnt + pending_cnt - CNT_W'(mem_resp.valid);
            credit_q    <= filled_cnt + CNT_W'(resp_drop);   // Stored lines come back at once
        end else begin
            if (issue_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (resp_fill) begin
                fill_ptr <= next_ptr(fill_ptr);
            end
            if (pop_ok) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            filled_cnt  <= filled_cnt + CNT_W'(resp_fill) - CNT_W'(pop_ok);
            pending_cnt <= pending_cnt + CNT_W'(issue_valid) - CNT_W'(resp_fill);
            drop_cnt    <= drop_cnt - CNT_W'(resp_drop);
            credit_q    <= CNT_W'(pop_ok) + CNT_W'(resp_drop);
        end
    end

    // Slot storage
    // The issue slot is always free and never the slot being filled
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            entries[wr_slot].pc         <= issue.pc;
            entries[wr_slot].start_word <= issue.start_word;
        end
        if (resp_fill) begin
            entries[fill_ptr].data <= mem_resp.data;
        end
    end

endmodule

`default_nettype wire

// File: source/inst_slicer.sv
`timescale 1ns/10ps
`default_nettype none

// Cuts the head line into 32-bit instructions
// Output register stays put while out_ready is low
module inst_slicer (
    input  wire logic                   clock,
    input  wire logic                   reset_n,
    input  wire fetch_pkg::buf_entry_t  head,
    input  wire logic                   head_valid,
    input  wire fetch_pkg::flush_t      flush,
    output logic                        pop,
    output fetch_pkg::fetch_inst_t      out,
    output logic                        out_valid,
    input  wire logic                   out_ready
);

    import fetch_pkg::*;

    slice_state_e       state;
    logic [WORD_W-1:0]  word;           // Word now on the output
    logic [WORD_W-1:0]  word_sel;       // Word to load next
    logic               last_word;
    logic               advance;
    logic               load;
    addr_t              word_pc;
    inst_t              word_inst;
    fetch_inst_t        out_q;

    assign out_valid = (state == SLICING);
    assign advance   = out_valid && out_ready;      // Item taken this cycle
    assign last_word = (word == 4'd15);
    assign pop       = advance && last_word;        // Frees the head line

    // First word of a new line comes from the entry, later ones step by one
    assign word_sel  = (state == EMPTY) ? head.start_word : word + 4'd1;
    assign word_pc   = head.pc + addr_t'({word_sel, 2'b00});
    assign word_inst = head.data[word_sel*INST_W +: INST_W];

    assign load = ((state == EMPTY) && head_valid) || (advance && !last_word);
    assign out  = out_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= EMPTY;
            word  <= '0;
        end else if (flush.valid) begin
            state <= EMPTY;                 // Current line is stale
        end else begin
            case (state)
                EMPTY: begin
                    if (head_valid) begin
                        state <= SLICING;
                        word  <= word_sel;
                    end
                end
                SLICING: begin
                    if (advance) begin
                        if (last_word) begin
                            state <= EMPTY; // Wait for the buffer to move its head
                        end else begin
                            word <= word_sel;
                        end
                    end
                end
                default: begin
                    state <= EMPTY;
                end
            endcase
        end
    end

    // Output payload, loaded only on a new word
    always_ff @(posedge clock) begin
        if (load) begin
            out_q <= '{pc: word_pc, inst: word_inst};
        end
    end

endmodule

`default_nettype wire

// File: source/fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

// Fetch front end
// pc_ctrl requests lines, line_buffer holds them, inst_slicer emits instructions
module fetch_top #(
    parameter int LINE_DEPTH = 4        // Buffered lines and initial credits, at least 2
) (
    input  wire logic                       clock,
    input  wire logic                       reset_n,
    input  wire fetch_pkg::addr_t           boot_addr,
    input  wire logic                       interrupt_valid,
    input  wire fetch_pkg::addr_t           interrupt_addr,
    input  wire logic                       redirect_valid,
    input  wire fetch_pkg::addr_t           redirect_target,
    output wire mem_pkg::mem_req_t          mem_req,
    input  wire logic                       mem_req_ready,
    input  wire mem_pkg::mem_resp_t         mem_resp,
    output wire fetch_pkg::fetch_inst_t     out,
    output wire logic                       out_valid,
    input  wire logic                       out_ready
);

    import fetch_pkg::*;

    localparam int CNT_W = $clog2(LINE_DEPTH + 1);

    wire buf_entry_t        issue;          // Line metadata at request time
    wire logic              issue_valid;
    wire flush_t            flush;
    wire buf_entry_t        head;
    wire logic              head_valid;
    wire logic              pop;
    wire logic [CNT_W-1:0]  credit_return;

    pc_ctrl #(
        .LINE_DEPTH (LINE_DEPTH)
    ) i_pc_ctrl (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .interrupt_valid (interrupt_valid),
        .interrupt_addr  (interrupt_addr),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .credit_return   (credit_return),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .issue           (issue),
        .issue_valid     (issue_valid),
        .flush           (flush)
    );

    line_buffer #(
        .LINE_DEPTH (LINE_DEPTH)
    ) i_line_buffer (
        .clock         (clock),
        .reset_n       (reset_n),
        .issue         (issue),
        .issue_valid   (issue_valid),
        .mem_resp      (mem_resp),
        .flush         (flush),
        .head          (head),
        .head_valid    (head_valid),
        .pop           (pop),
        .credit_return (credit_return)
    );

    inst_slicer i_inst_slicer (
        .clock      (clock),
        .reset_n    (reset_n),
        .head       (head),
        .head_valid (head_valid),
        .flush      (flush),
        .pop        (pop),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: sim/tb_fetch_top.sv
`timescale 1ns/10ps
`default_nettype none

// Fetch front end testbench
// In-order memory model with random stalls
// Output is checked against the expected PC stream
module tb_fetch_top;

    import fetch_pkg::*;
    import mem_pkg::*;

    localparam int LINE_DEPTH   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_TESTS    = 32;
    localparam int INST_BUDGET  = 200;      // Watchdog cycles per expected instruction

    logic               clock;
    logic               reset_n;
    addr_t              boot_addr;
    logic               interrupt_valid;
    addr_t              interrupt_addr;
    logic               redirect_valid;
    addr_t              redirect_target;
    wire mem_req_t      mem_req;
    logic               mem_req_ready;
    mem_resp_t          mem_resp;
    wire fetch_inst_t   out;
    wire logic          out_valid;
    logic               out_ready;

    int                 num_tests;
    int                 t_id [MAX_TESTS];
    addr_t              t_boot [MAX_TESTS];
    int                 t_count [MAX_TESTS];
    int                 t_kind [MAX_TESTS];     // 0 none, 1 redirect, 2 interrupt, 3 both
    int                 t_after [MAX_TESTS];
    addr_t              t_target [MAX_TESTS];
    addr_t              t_alt [MAX_TESTS];      // Losing redirect target for kind 3

    line_index_t        req_q [$];              // Accepted requests awaiting a response
    int                 due_q [$];
    logic [31:0]        lfsr;
    int                 cyc;
    int                 limit_cycles;
    int                 checks;
    int                 errors;
    int                 seen;                   // Instructions taken in this test
    int                 restart_cyc;
    addr_t              exp_pc;                 // Next PC of the stream on the output
    addr_t              new_pc;                 // Restart target, word aligned
    logic               restart_pending;        // Target not yet seen on the output
    logic               fired;
    logic               prev_stall;
    fetch_inst_t        prev_out;
    logic [21:0]        req_line;               // Next expected request, low address bits
    logic [21:0]        req_new_line;
    logic               req_switch;             // Next request starts the new stream

    fetch_top #(
        .LINE_DEPTH (LINE_DEPTH)
    ) i_dut (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .interrupt_valid (interrupt_valid),
        .interrupt_addr  (interrupt_addr),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .mem_resp        (mem_resp),
        .out             (out),
        .out_valid       (out_valid),
        .out_ready       (out_ready)
    );

    always #20 clock = ~clock;  // 40 ns period

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int b = 0; b < n; b++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};     // One step per bit
        end
    endtask

    // Each word holds the low 22 bits of its own byte address
    function automatic line_data_t line_words(input line_index_t index);
        line_data_t data;
        for (int w = 0; w < 16; w++) begin
            data[w*32 +: 32] = {10'b0, index, 3'b000} + 32'(4 * w);
        end
        return data;
    endfunction

    task automatic check_that(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("Error at %0d ns: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic read_stimulus(output logic ok);
        int               fd;
        int               n;
        logic [8*160-1:0] text;
        num_tests = 0;
        fd = $fopen("sim/fetch_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                text = '0;
                n = $fgets(text, fd);
                n = $sscanf(text, "%d %h %d %d %d %h %h", t_id[num_tests], t_boot[num_tests],
                            t_count[num_tests], t_kind[num_tests], t_after[num_tests],
                            t_target[num_tests], t_alt[num_tests]);
                if (n == 7) begin
                    num_tests++;                // Comment and blank lines do not parse
                end
            end
            $fclose(fd);
        end
        ok = (num_tests > 0);
    endtask

    task automatic check_output();
        check_that(out.inst == {10'b0, out.pc[21:0]},
                   $sformatf("PC %h carries instruction %h", out.pc, out.inst));
        if (restart_pending && out.pc == new_pc) begin
            restart_pending = 1'b0;             // Old stream may not come back
            exp_pc          = new_pc;
        end
        check_that(out.pc == exp_pc, $sformatf("PC %h, expected %h", out.pc, exp_pc));
        exp_pc = exp_pc + addr_t'(4);
    endtask

    task automatic serve_memory();
        logic [31:0] r;
        mem_resp.valid = 1'b0;
        if (req_q.size() != 0 && due_q[0] <= cyc) begin
            mem_resp.data  = line_words(req_q.pop_front());
            mem_resp.valid = 1'b1;
            due_q.delete(0);
        end
        // Accepted at the coming rising edge
        if (mem_req.valid && mem_req_ready) begin
            if (req_switch) begin
                req_line   = req_new_line;
                req_switch = 1'b0;
            end
            check_that(mem_req.index == req_line[21:3],
                       $sformatf("request index %h, expected %h", mem_req.index, req_line[21:3]));
            req_line = req_line + 22'd64;
            random_bits(2, r);
            req_q.push_back(mem_req.index);
            due_q.push_back(cyc + 1 + int'(r[1:0]));    // Latency 1 to 4 cycles
            check_that(req_q.size() <= LINE_DEPTH, "more requests in flight than credits");
        end
    endtask

    task automatic fire_restart(input int i);
        fired           = 1'b1;
        restart_pending = 1'b1;
        restart_cyc     = cyc;
        req_switch      = 1'b1;
        new_pc          = {t_target[i][47:2], 2'b00};   // Bits 1 to 0 ignored
        req_new_line    = {t_target[i][21:6], 6'b0};
        interrupt_valid = (t_kind[i] >= 2);
        redirect_valid  = (t_kind[i] == 1 || t_kind[i] == 3);
        interrupt_addr  = t_target[i];
        redirect_target = (t_kind[i] == 3) ? t_alt[i] : t_target[i];
    endtask

    task automatic step_cycle(input int i, input logic drain);
        logic [31:0] r;
        @(negedge clock);
        cyc++;
        interrupt_valid = 1'b0;
        redirect_valid  = 1'b0;
        // The slicer may drop a stalled item two cycles after a restart
        if (prev_stall && (cyc - restart_cyc) > 2) begin
            check_that(out_valid && out == prev_out, "output changed while stalled");
        end
        random_bits(2, r);
        out_ready = (r[1:0] != 2'b00);
        random_bits(2, r);
        mem_req_ready = !drain && (r[1:0] != 2'b00);
        if (out_valid && out_ready) begin
            check_output();
            seen++;
        end
        prev_stall = out_valid && !out_ready;
        prev_out   = out;
        serve_memory();
        if (!fired && t_kind[i] != 0 && seen >= t_after[i]) begin
            fire_restart(i);
        end
    endtask

    task automatic run_test(input int i);
        int err_start;
        err_start = errors;
        @(negedge clock);
        reset_n       = 1'b0;
        boot_addr     = t_boot[i];
        mem_req_ready = 1'b0;
        out_ready     = 1'b0;
        mem_resp      = '0;
        repeat (RESET_CYCLES) begin
            @(negedge clock);
            check_that(!mem_req.valid && !out_valid, "request or output valid in reset");
        end
        reset_n         = 1'b1;
        exp_pc          = {t_boot[i][47:6], 6'b0};      // Boot stream starts at the line base
        req_line        = {t_boot[i][21:6], 6'b0};
        restart_pending = 1'b0;
        fired           = 1'b0;
        req_switch      = 1'b0;
        prev_stall      = 1'b0;
        restart_cyc     = -100;
        seen            = 0;
        while (seen < t_count[i]) begin
            step_cycle(i, 1'b0);
        end
        while (req_q.size() != 0) begin
            step_cycle(i, 1'b1);                // No new requests while the last ones return
        end
        if (t_kind[i] != 0) begin
            check_that(fired && !restart_pending, "restart target never reached the output");
        end
        $display("Test %0d: %0d instructions, %0d errors", t_id[i], seen, errors - err_start);
    endtask

    initial begin : main
        logic ok;
        int   total;
        clock           = 1'b0;
        reset_n         = 1'b0;
        boot_addr       = '0;
        interrupt_valid = 1'b0;
        interrupt_addr  = '0;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        mem_req_ready   = 1'b0;
        mem_resp        = '0;
        out_ready       = 1'b0;
        lfsr            = 32'h9093;
        read_stimulus(ok);
        if (ok) begin
            total = 0;
            for (int i = 0; i < num_tests; i++) begin
                total += t_count[i];
            end
            limit_cycles = total * INST_BUDGET + num_tests * (RESET_CYCLES + 2);
            for (int i = 0; i < num_tests; i++) begin
                run_test(i);
            end
            $display("Tests: %0d, checks: %0d, errors: %0d", num_tests, checks, errors);
        end else begin
            $display("No test could be read from sim/fetch_stimulus.txt");
        end
        if (ok && errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Ends a run that stops making progress
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/fetch_stimulus.txt
# test boot_addr count kind after target alt_target
# kind 0 none, 1 redirect, 2 interrupt, 3 both (interrupt to target, redirect to alt_target)
1  000000001000   64  0   0  000000000000  000000000000
2  0000abcd0024   48  0   0  000000000000  000000000000
3  000000002000   64  1  10  000000008010  000000000000
4  000100004000   64  2  25  00000000c03c  000000000000
5  000000006000   64  3  17  0000000a0104  0000000b0200
6  7fff00010000   48  1   0  0000003fffc0  000000000000
7  000000030000   64  1   3  000000020047  000000000000
8  000000040000   64  2  40  00000005003c  000000000000
9  123456780000  160  0   0  000000000000  000000000000
10 00000007ffc0   64  3   1  000000100020  000000100000

// File: verilog.f
source/mem_pkg.sv
source/fetch_pkg.sv
source/pc_ctrl.sv
source/line_buffer.sv
source/inst_slicer.sv
source/fetch_top.sv
sim/tb_fetch_top.sv

// File: Bender.yml
package:
  name: fetch_front_end

sources:
  - source/mem_pkg.sv
  - source/fetch_pkg.sv
  - source/pc_ctrl.sv
  - source/line_buffer.sv
  - source/inst_slicer.sv
  - source/fetch_top.sv
  - target: test
    files:
      - sim/tb_fetch_top.sv
